// ==== rtl/eth_mgmt_pkg.sv ====
/*
  Shared types for the Ethernet management block: register map,
  FSM state and MDIO opcode enums, request/response structs, MDIO constants
*/
package eth_mgmt_pkg;

  typedef logic [11:0] reg_idx_t;
  typedef logic [31:0] reg_data_t;

  typedef enum logic [11:0] {
    REG_SCRATCH0   = 12'd0,
    REG_SCRATCH1   = 12'd1,
    REG_SCRATCH2   = 12'd2,
    REG_SCRATCH3   = 12'd3,
    REG_MDIO_CMD   = 12'd4,
    REG_MDIO_WDATA = 12'd5,
    REG_MDIO_RDATA = 12'd6,
    REG_MDIO_CTRL  = 12'd7
  } mgmt_reg_e;

  // Command bit 10
  typedef enum logic {
    MDIO_OP_WRITE = 1'b0,
    MDIO_OP_READ  = 1'b1
  } mdio_op_e;

  typedef enum logic [1:0] {WR_IDLE, WR_WDATA_WAIT, WR_REQ, WR_RESP} axi_wr_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_RESP} axi_rd_state_e;

  typedef struct packed {
    logic      valid;
    reg_idx_t  idx;
    reg_data_t data;
  } reg_wr_req_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t idx;
  } reg_rd_req_t;

  typedef struct packed {
    logic      done;
    reg_data_t data;
  } reg_rd_rsp_t;

  typedef struct packed {
    mdio_op_e    op;
    logic [4:0]  phy_addr;
    logic [4:0]  reg_addr;
    logic [15:0] wdata;
  } mdio_cmd_t;

  typedef struct packed {
    logic        busy;
    logic        init;
    logic [15:0] rdata;
  } mdio_stat_t;

  // 33 MDC periods, two counts each
  localparam int MDIO_FRAME_LAST = 65;
  localparam int MDIO_TA_COUNT   = 29;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

// ==== rtl/axi_wr_chan.sv ====
/*
  AXI4-Lite write channel FSM
  One register write request per transaction, response held until bready
*/
`timescale 1ns/1ns

module axi_wr_chan (
  input  logic                      s_axi_aclk,
  input  logic                      s_axi_aresetn,
  input  logic [13:0]               s_axi_awaddr_i,
  input  logic                      s_axi_awvalid_i,
  output logic                      s_axi_awready_o,
  input  logic [31:0]               s_axi_wdata_i,
  input  logic                      s_axi_wvalid_i,
  output logic                      s_axi_wready_o,
  output logic [1:0]                s_axi_bresp_o,
  output logic                      s_axi_bvalid_o,
  input  logic                      s_axi_bready_i,
  output eth_mgmt_pkg::reg_wr_req_t reg_wr_o
);

  import eth_mgmt_pkg::*;

  axi_wr_state_e wr_state_q;
  reg_idx_t      wr_idx_q;
  reg_data_t     wr_data_q;

  assign reg_wr_o.valid = (wr_state_q == WR_REQ);
  assign reg_wr_o.idx   = wr_idx_q;
  assign reg_wr_o.data  = wr_data_q;
  assign s_axi_bresp_o  = AXI_RESP_OKAY;

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      s_axi_awready_o <= 1'b1;
      s_axi_wready_o  <= 1'b1;
      s_axi_bvalid_o  <= 1'b0;
      wr_state_q      <= WR_IDLE;
    end else begin
      case (wr_state_q)
        WR_IDLE: begin
          if (s_axi_awvalid_i) begin
            s_axi_awready_o <= 1'b0;
            if (s_axi_wvalid_i) begin
              s_axi_wready_o <= 1'b0;
              wr_state_q     <= WR_REQ;
            end else begin
              wr_state_q <= WR_WDATA_WAIT;
            end
          end
        end
        WR_WDATA_WAIT: begin
          if (s_axi_wvalid_i) begin
            s_axi_wready_o <= 1'b0;
            wr_state_q     <= WR_REQ;
          end
        end
        // Register write lands at this edge
        WR_REQ: begin
          s_axi_bvalid_o <= 1'b1;
          wr_state_q     <= WR_RESP;
        end
        WR_RESP: begin
          if (s_axi_bready_i) begin
            s_axi_bvalid_o  <= 1'b0;
            s_axi_awready_o <= 1'b1;
            s_axi_wready_o  <= 1'b1;
            wr_state_q      <= WR_IDLE;
          end
        end
        default: wr_state_q <= WR_IDLE;
      endcase
    end
  end

  // Address and data capture
  always_ff @(posedge s_axi_aclk) begin
    if (wr_state_q == WR_IDLE && s_axi_awvalid_i) begin
      wr_idx_q <= s_axi_awaddr_i[13:2];
    end
    if ((wr_state_q == WR_IDLE && s_axi_awvalid_i && s_axi_wvalid_i) ||
        (wr_state_q == WR_WDATA_WAIT && s_axi_wvalid_i)) begin
      wr_data_q <= s_axi_wdata_i;
    end
  end

  a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o);

endmodule

// ==== rtl/axi_rd_chan.sv ====
/*
  AXI4-Lite read channel FSM
  Issues one register read and holds rdata until rready
*/
`timescale 1ns/1ns

module axi_rd_chan (
  input  logic                      s_axi_aclk,
  input  logic                      s_axi_aresetn,
  input  logic [13:0]               s_axi_araddr_i,
  input  logic                      s_axi_arvalid_i,
  output logic                      s_axi_arready_o,
  output logic [31:0]               s_axi_rdata_o,
  output logic [1:0]                s_axi_rresp_o,
  output logic                      s_axi_rvalid_o,
  input  logic                      s_axi_rready_i,
  output eth_mgmt_pkg::reg_rd_req_t reg_rd_o,
  input  eth_mgmt_pkg::reg_rd_rsp_t reg_rsp_i
);

  import eth_mgmt_pkg::*;

  axi_rd_state_e rd_state_q;
  reg_idx_t      rd_idx_q;

  assign reg_rd_o.valid = (rd_state_q == RD_REQ);
  assign reg_rd_o.idx   = rd_idx_q;
  assign s_axi_rresp_o  = AXI_RESP_OKAY;

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      s_axi_arready_o <= 1'b1;
      s_axi_rvalid_o  <= 1'b0;
      s_axi_rdata_o   <= '0;
      rd_state_q      <= RD_IDLE;
    end else begin
      case (rd_state_q)
        RD_IDLE: begin
          if (s_axi_arvalid_i) begin
            s_axi_arready_o <= 1'b0;
            rd_state_q      <= RD_REQ;
          end
        end
        RD_REQ: begin
          if (reg_rsp_i.done) begin
            s_axi_rvalid_o <= 1'b1;
            s_axi_rdata_o  <= reg_rsp_i.data;
            rd_state_q     <= RD_RESP;
          end
        end
        RD_RESP: begin
          if (s_axi_rready_i) begin
            s_axi_rvalid_o  <= 1'b0;
            s_axi_arready_o <= 1'b1;
            rd_state_q      <= RD_IDLE;
          end
        end
        default: rd_state_q <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (rd_state_q == RD_IDLE && s_axi_arvalid_i) begin
      rd_idx_q <= s_axi_araddr_i[13:2];
    end
  end

  a_rdata_stable: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_rvalid_o && !s_axi_rready_i |=> $stable(s_axi_rdata_o));

endmodule

// ==== rtl/mgmt_regs.sv ====
/*
  Management register block shared by the AXI read and write channels
  Scratch registers, MDIO command/data/control and the read mux
*/
`timescale 1ns/1ns

module mgmt_regs #(
  parameter int unsigned PHY_ADDR_RST = 1
) (
  input  logic                      s_axi_aclk,
  input  logic                      s_axi_aresetn,
  input  eth_mgmt_pkg::reg_wr_req_t reg_wr_i,
  input  eth_mgmt_pkg::reg_rd_req_t reg_rd_i,
  output eth_mgmt_pkg::reg_rd_rsp_t reg_rsp_o,
  output eth_mgmt_pkg::mdio_cmd_t   mdio_cmd_o,
  output logic                      mdio_start_o,
  input  eth_mgmt_pkg::mdio_stat_t  mdio_stat_i
);

  import eth_mgmt_pkg::*;

  reg_data_t scratch_q [4];
  mdio_cmd_t mdio_cmd_q;
  logic      mdio_en_q;
  logic      rd_done_q;
  reg_data_t rd_data;

  // ========================================
  // Write decode
  // ========================================
  // Enable is sampled before this write updates it
  assign mdio_start_o = reg_wr_i.valid && (reg_wr_i.idx == REG_MDIO_CTRL) &&
                        reg_wr_i.data[0] && mdio_en_q;

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      for (int i = 0; i < 4; i++) begin
        scratch_q[i] <= '0;
      end
      mdio_cmd_q <= '{op: MDIO_OP_WRITE, phy_addr: 5'(PHY_ADDR_RST), reg_addr: '0, wdata: '0};
      mdio_en_q  <= 1'b1;
      rd_done_q  <= 1'b0;
    end else begin
      rd_done_q <= reg_rd_i.valid;
      if (reg_wr_i.valid) begin
        case (reg_wr_i.idx)
          REG_SCRATCH0, REG_SCRATCH1, REG_SCRATCH2, REG_SCRATCH3:
            scratch_q[reg_wr_i.idx[1:0]] <= reg_wr_i.data;
          REG_MDIO_CMD: begin
            mdio_cmd_q.op       <= mdio_op_e'(reg_wr_i.data[10]);
            mdio_cmd_q.phy_addr <= reg_wr_i.data[9:5];
            mdio_cmd_q.reg_addr <= reg_wr_i.data[4:0];
          end
          REG_MDIO_WDATA:
            mdio_cmd_q.wdata <= reg_wr_i.data[15:0];
          REG_MDIO_CTRL:
            mdio_en_q <= reg_wr_i.data[1];
          default: ;
        endcase
      end
    end
  end

  // ========================================
  // Read mux
  // ========================================
  always_comb begin
    case (reg_rd_i.idx)
      REG_SCRATCH0, REG_SCRATCH1, REG_SCRATCH2, REG_SCRATCH3:
        rd_data = scratch_q[reg_rd_i.idx[1:0]];
      REG_MDIO_CMD:
        rd_data = {21'h0, mdio_cmd_q.op, mdio_cmd_q.phy_addr, mdio_cmd_q.reg_addr};
      REG_MDIO_WDATA:
        rd_data = {16'h0, mdio_cmd_q.wdata};
      REG_MDIO_RDATA:
        rd_data = {16'h0, mdio_stat_i.rdata};
      REG_MDIO_CTRL:
        rd_data = {29'h0, mdio_stat_i.init, mdio_en_q, mdio_stat_i.busy};
      default:
        rd_data = '0;
    endcase
  end

  assign reg_rsp_o.done = rd_done_q;
  assign reg_rsp_o.data = rd_data;
  assign mdio_cmd_o     = mdio_cmd_q;

endmodule

// ==== rtl/mdio_master.sv ====
/*
  Clause-22 MDIO master
  MDC generation, post-reset preamble, frame shift out and read shift in
*/
`timescale 1ns/1ns

module mdio_master #(
  parameter int unsigned MDIO_INIT_LAST = 125
) (
  input  logic                     s_axi_aclk,
  input  logic                     s_axi_aresetn,
  input  eth_mgmt_pkg::mdio_cmd_t  mdio_cmd_i,
  input  logic                     mdio_start_i,
  output eth_mgmt_pkg::mdio_stat_t mdio_stat_o,
  input  logic                     phy_mdio_i,
  output logic                     phy_mdio_o,
  output logic                     phy_mdio_t,
  output logic                     phy_mdc
);

  import eth_mgmt_pkg::*;

  logic [6:0]  cnt_q;
  logic [5:0]  mdc_period;
  logic        busy_q;
  logic        init_q;
  logic        is_read;
  logic        init_end;
  logic        frame_end;
  logic [15:0] rdata_q;
  logic [31:0] frame;

  assign mdc_period = cnt_q[6:1];
  assign is_read    = (mdio_cmd_i.op == MDIO_OP_READ);
  assign init_end   = init_q && (cnt_q == 7'(MDIO_INIT_LAST));
  assign frame_end  = busy_q && (cnt_q == 7'(MDIO_FRAME_LAST));

  // ST, OP, PHYAD, REGAD, TA, DATA in transmit order
  assign frame = {2'b01, mdio_cmd_i.op, ~mdio_cmd_i.op, mdio_cmd_i.phy_addr,
                  mdio_cmd_i.reg_addr, 2'b10, is_read ? 16'h0 : mdio_cmd_i.wdata};

  // ========================================
  // Counter, busy and init
  // ========================================
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
      init_q <= 1'b1;
    end else begin
      if (mdio_start_i) begin
        busy_q <= 1'b1;
      end else if (frame_end) begin
        busy_q <= 1'b0;
      end

      if (init_end) begin
        init_q <= 1'b0;
      end

      if (init_end || frame_end) begin
        cnt_q <= '0;
      end else if (init_q || busy_q) begin
        cnt_q <= cnt_q + 7'd1;
      end
    end
  end

  // ========================================
  // Line drive and sampling
  // ========================================
  // Odd counts are the MDC falling edge
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      phy_mdio_o <= 1'b1;
      rdata_q    <= '0;
    end else begin
      if (busy_q && cnt_q[0]) begin
        // 31 - period picks the bit, MSB first
        phy_mdio_o <= mdc_period[5] ? 1'b1 : frame[~mdc_period[4:0]];
      end
      // Periods 16 to 31 carry read data
      if (busy_q && is_read && cnt_q[0] && (mdc_period[5:4] == 2'b01)) begin
        rdata_q <= {rdata_q[14:0], phy_mdio_i};
      end
    end
  end

  // Release the line after turnaround on reads
  assign phy_mdio_t = busy_q && is_read && (cnt_q > 7'(MDIO_TA_COUNT));
  assign phy_mdc    = cnt_q[0];

  assign mdio_stat_o.busy  = busy_q;
  assign mdio_stat_o.init  = init_q;
  assign mdio_stat_o.rdata = rdata_q;

  a_no_start_busy: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    mdio_start_i |-> !busy_q);

endmodule

// ==== rtl/eth_mgmt_top.sv ====
/*
  Ethernet MAC management top level
  AXI4-Lite read/write channels, register block and MDIO master
*/
`timescale 1ns/1ns

module eth_mgmt_top #(
  parameter int unsigned MDIO_INIT_LAST = 125,
  parameter int unsigned PHY_ADDR_RST   = 1
) (
  input  logic        s_axi_aclk,
  input  logic        s_axi_aresetn,
  input  logic [13:0] s_axi_awaddr_i,
  input  logic        s_axi_awvalid_i,
  output logic        s_axi_awready_o,
  input  logic [31:0] s_axi_wdata_i,
  input  logic        s_axi_wvalid_i,
  output logic        s_axi_wready_o,
  output logic [1:0]  s_axi_bresp_o,
  output logic        s_axi_bvalid_o,
  input  logic        s_axi_bready_i,
  input  logic [13:0] s_axi_araddr_i,
  input  logic        s_axi_arvalid_i,
  output logic        s_axi_arready_o,
  output logic [31:0] s_axi_rdata_o,
  output logic [1:0]  s_axi_rresp_o,
  output logic        s_axi_rvalid_o,
  input  logic        s_axi_rready_i,
  output logic        phy_rst_n,
  input  logic        phy_mdio_i,
  output logic        phy_mdio_o,
  output logic        phy_mdio_t,
  output logic        phy_mdc
);

  import eth_mgmt_pkg::*;

  reg_wr_req_t reg_wr;
  reg_rd_req_t reg_rd;
  reg_rd_rsp_t reg_rsp;
  mdio_cmd_t   mdio_cmd;
  mdio_stat_t  mdio_stat;
  logic        mdio_start;

  assign phy_rst_n = s_axi_aresetn;

  axi_wr_chan axi_wr_chan_inst (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .reg_wr_o        (reg_wr)
  );

  axi_rd_chan axi_rd_chan_inst (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .reg_rd_o        (reg_rd),
    .reg_rsp_i       (reg_rsp)
  );

  mgmt_regs #(
    .PHY_ADDR_RST (PHY_ADDR_RST)
  ) mgmt_regs_inst (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .reg_wr_i      (reg_wr),
    .reg_rd_i      (reg_rd),
    .reg_rsp_o     (reg_rsp),
    .mdio_cmd_o    (mdio_cmd),
    .mdio_start_o  (mdio_start),
    .mdio_stat_i   (mdio_stat)
  );

  mdio_master #(
    .MDIO_INIT_LAST (MDIO_INIT_LAST)
  ) mdio_master_inst (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .mdio_cmd_i    (mdio_cmd),
    .mdio_start_i  (mdio_start),
    .mdio_stat_o   (mdio_stat),
    .phy_mdio_i    (phy_mdio_i),
    .phy_mdio_o    (phy_mdio_o),
    .phy_mdio_t    (phy_mdio_t),
    .phy_mdc       (phy_mdc)
  );

endmodule

// ==== dv/mdio_phy_model.sv ====
/*
  Behavioral MDIO PHY
  Captures the last 32 frame bits driven by the master and answers reads
*/
`timescale 1ns/1ns

module mdio_phy_model (
  input  logic        mdc_i,
  input  logic        mdio_line_i,
  input  logic        mdio_t_i,
  output logic        mdio_line_o,
  input  logic [15:0] rsp_data_i,
  output logic [31:0] frame_o
);

  logic [31:0] frame_q  = '0;
  logic        line_q   = 1'b1;
  int unsigned rise_cnt = 0;

  assign frame_o     = frame_q;
  assign mdio_line_o = line_q;

  // Master owns the line while t is low
  always @(posedge mdc_i) begin
    if (!mdio_t_i) begin
      frame_q  <= {frame_q[30:0], mdio_line_i};
      rise_cnt <= 0;
    end else begin
      rise_cnt <= rise_cnt + 1;
    end
  end

  // First released edge is turnaround, then 16 data bits MSB first
  always @(negedge mdc_i) begin
    if (rise_cnt >= 1 && rise_cnt <= 16) begin
      line_q <= rsp_data_i[16 - rise_cnt];
    end else begin
      line_q <= 1'b1;
    end
  end

endmodule

// ==== dv/tb_eth_mgmt.sv ====
/*
  Testbench for the Ethernet management block
  Clock, reset, AXI4-Lite driver tasks, directed tests, LFSR, timeout
*/
`timescale 1ns/1ns

module tb_eth_mgmt;

  // About 700 cycles of tests plus a wide margin
  localparam int TIMEOUT_CYCLES = 6000;
  localparam logic [13:0] ADDR_CMD   = 14'h10;
  localparam logic [13:0] ADDR_WDATA = 14'h14;
  localparam logic [13:0] ADDR_RDATA = 14'h18;
  localparam logic [13:0] ADDR_CTRL  = 14'h1c;

  logic        clk;
  logic        aresetn;
  logic [13:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [13:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        phy_rst_n;
  logic        mdio_in;
  logic        mdio_out;
  logic        mdio_t;
  logic        mdc;
  logic [15:0] phy_rsp;
  logic [31:0] phy_frame;
  logic [31:0] lfsr_q;
  int          cycle_cnt = 0;
  int          errors;
  int          tests_run;
  int          tests_failed;

  eth_mgmt_top eth_mgmt_top_inst (
    .s_axi_aclk      (clk),
    .s_axi_aresetn   (aresetn),
    .s_axi_awaddr_i  (awaddr),
    .s_axi_awvalid_i (awvalid),
    .s_axi_awready_o (awready),
    .s_axi_wdata_i   (wdata),
    .s_axi_wvalid_i  (wvalid),
    .s_axi_wready_o  (wready),
    .s_axi_bresp_o   (bresp),
    .s_axi_bvalid_o  (bvalid),
    .s_axi_bready_i  (bready),
    .s_axi_araddr_i  (araddr),
    .s_axi_arvalid_i (arvalid),
    .s_axi_arready_o (arready),
    .s_axi_rdata_o   (rdata),
    .s_axi_rresp_o   (rresp),
    .s_axi_rvalid_o  (rvalid),
    .s_axi_rready_i  (rready),
    .phy_rst_n       (phy_rst_n),
    .phy_mdio_i      (mdio_in),
    .phy_mdio_o      (mdio_out),
    .phy_mdio_t      (mdio_t),
    .phy_mdc         (mdc)
  );

  mdio_phy_model mdio_phy_model_inst (
    .mdc_i       (mdc),
    .mdio_line_i (mdio_out),
    .mdio_t_i    (mdio_t),
    .mdio_line_o (mdio_in),
    .rsp_data_i  (phy_rsp),
    .frame_o     (phy_frame)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED @ %0t ns: %s, got 0x%08h expected 0x%08h", $time, what, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR @ %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic finish_test(input string name, input int err_at_start);
    tests_run++;
    if (errors == err_at_start) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - err_at_start);
    end
  endtask

  // ========================================
  // AXI4-Lite driver tasks
  // ========================================
  task automatic axi_write(input logic [13:0] addr, input logic [31:0] data,
                           input int wdelay, input int bp);
    int lat;
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= (wdelay == 0);
    bready  <= 1'b0;
    @(posedge clk);
    awvalid <= 1'b0;
    if (wdelay > 0) begin
      repeat (wdelay - 1) @(posedge clk);
      wvalid <= 1'b1;
      @(posedge clk);
    end
    wvalid <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!bvalid && lat < 20);
    if (!bvalid) begin
      report_problem($sformatf("no write response for address 0x%04h", addr));
      return;
    end
    if (lat != 2) report_mismatch("bvalid latency", lat, 2);
    if (bresp !== 2'b00) report_mismatch("bresp", bresp, 0);
    repeat (bp) begin
      @(negedge clk);
      if (bvalid !== 1'b1) report_mismatch("bvalid under back-pressure", bvalid, 1);
      if (awready !== 1'b0) report_mismatch("awready under back-pressure", awready, 0);
    end
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
    @(negedge clk);
    if (bvalid !== 1'b0) report_mismatch("bvalid after bready", bvalid, 0);
    if (awready !== 1'b1) report_mismatch("awready after response", awready, 1);
    if (wready !== 1'b1) report_mismatch("wready after response", wready, 1);
  endtask

  task automatic axi_read(input logic [13:0] addr, input int bp, output logic [31:0] data);
    int lat;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b0;
    @(posedge clk);
    arvalid <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!rvalid && lat < 20);
    data = rdata;
    if (!rvalid) begin
      report_problem($sformatf("no read response for address 0x%04h", addr));
      return;
    end
    // Edge 0 samples arvalid and rvalid shows after edge 2
    if (lat != 3) report_mismatch("rvalid latency", lat, 3);
    if (rresp !== 2'b00) report_mismatch("rresp", rresp, 0);
    repeat (bp) begin
      @(negedge clk);
      if (rvalid !== 1'b1) report_mismatch("rvalid under back-pressure", rvalid, 1);
      if (rdata !== data) report_mismatch("rdata under back-pressure", rdata, data);
      if (arready !== 1'b0) report_mismatch("arready under back-pressure", arready, 0);
    end
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
    @(negedge clk);
    if (rvalid !== 1'b0) report_mismatch("rvalid after rready", rvalid, 0);
    if (arready !== 1'b1) report_mismatch("arready after response", arready, 1);
  endtask

  task automatic poll_ctrl_clear(input logic [31:0] mask, input int limit, input string what);
    logic [31:0] d;
    int          start;
    start = cycle_cnt;
    axi_read(ADDR_CTRL, 0, d);
    while ((d & mask) != 0 && (cycle_cnt - start) < limit) begin
      axi_read(ADDR_CTRL, 0, d);
    end
    if ((d & mask) != 0) report_problem({what, " did not clear in time"});
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic check_reset_state();
    int          err0;
    logic [31:0] d;
    err0 = errors;
    repeat (4) @(posedge clk);
    if (phy_rst_n !== 1'b0) report_mismatch("phy_rst_n during reset", phy_rst_n, 0);
    aresetn <= 1'b1;
    @(negedge clk);
    if (arready !== 1'b1) report_mismatch("arready after reset", arready, 1);
    if (awready !== 1'b1) report_mismatch("awready after reset", awready, 1);
    if (wready !== 1'b1) report_mismatch("wready after reset", wready, 1);
    if (rvalid !== 1'b0) report_mismatch("rvalid after reset", rvalid, 0);
    if (bvalid !== 1'b0) report_mismatch("bvalid after reset", bvalid, 0);
    if (mdio_out !== 1'b1) report_mismatch("phy_mdio_o after reset", mdio_out, 1);
    if (mdio_t !== 1'b0) report_mismatch("phy_mdio_t after reset", mdio_t, 0);
    if (phy_rst_n !== 1'b1) report_mismatch("phy_rst_n after reset", phy_rst_n, 1);
    axi_read(ADDR_CMD, 0, d);
    if (d !== 32'h20) report_mismatch("MDIO command reset value", d, 32'h20);
    axi_read(ADDR_CTRL, 0, d);
    if (d !== 32'h6) report_mismatch("MDIO control reset value", d, 32'h6);
    axi_read(14'h50, 0, d);
    if (d !== 32'h0) report_mismatch("unmapped register", d, 0);
    poll_ctrl_clear(32'h4, 200, "MDIO init");
    finish_test("reset state", err0);
  endtask

  task automatic scratch_readback();
    int          err0;
    logic [31:0] exp [4];
    logic [31:0] d;
    err0 = errors;
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < 4; i++) begin
        exp[i] = lfsr_bits(32);
        axi_write(14'(i * 4), exp[i], pass * 3, 0);
      end
      for (int i = 0; i < 4; i++) begin
        axi_read(14'(i * 4), 0, d);
        if (d !== exp[i]) report_mismatch($sformatf("scratch %0d readback", i), d, exp[i]);
      end
    end
    finish_test("scratch registers", err0);
  endtask

  task automatic mdio_write_frame();
    int          err0;
    logic [4:0]  phy;
    logic [4:0]  regad;
    logic [15:0] wd;
    logic [31:0] exp;
    err0  = errors;
    phy   = 5'(lfsr_bits(5));
    regad = 5'(lfsr_bits(5));
    wd    = 16'(lfsr_bits(16));
    axi_write(ADDR_CMD, {21'h0, 1'b0, phy, regad}, 0, 0);
    axi_write(ADDR_WDATA, {16'h0, wd}, 0, 0);
    axi_write(ADDR_CTRL, 32'h3, 0, 0);
    poll_ctrl_clear(32'h1, 200, "MDIO busy on write");
    exp = {2'b01, 2'b01, phy, regad, 2'b10, wd};
    if (phy_frame !== exp) report_mismatch("captured MDIO write frame", phy_frame, exp);
    finish_test("MDIO write", err0);
  endtask

  task automatic mdio_read_frame();
    int          err0;
    logic [4:0]  phy;
    logic [4:0]  regad;
    logic [31:0] d;
    err0    = errors;
    phy     = 5'(lfsr_bits(5));
    regad   = 5'(lfsr_bits(5));
    phy_rsp = 16'(lfsr_bits(16));
    axi_write(ADDR_CMD, {21'h0, 1'b1, phy, regad}, 0, 0);
    axi_write(ADDR_CTRL, 32'h3, 0, 0);
    poll_ctrl_clear(32'h1, 200, "MDIO busy on read");
    axi_read(ADDR_RDATA, 0, d);
    if (d !== {16'h0, phy_rsp}) report_mismatch("MDIO read data", d, {16'h0, phy_rsp});
    // Only ST, OP and the addresses go out before the line is released
    if (phy_frame[13:0] !== {2'b01, 2'b10, phy, regad}) begin
      report_mismatch("captured MDIO read header", phy_frame[13:0], {2'b01, 2'b10, phy, regad});
    end
    finish_test("MDIO read", err0);
  endtask

  task automatic back_pressure_hold();
    int          err0;
    logic [31:0] v;
    logic [31:0] d;
    err0 = errors;
    v    = lfsr_bits(32);
    axi_write(14'h8, v, 0, 10);
    axi_read(14'h8, 10, d);
    if (d !== v) report_mismatch("readback under back-pressure", d, v);
    finish_test("back-pressure", err0);
  endtask

  task automatic mdio_disabled();
    int          err0;
    logic [31:0] d;
    err0 = errors;
    axi_write(ADDR_CTRL, 32'h0, 0, 0);
    axi_write(ADDR_CTRL, 32'h1, 0, 0);
    axi_read(ADDR_CTRL, 0, d);
    if (d !== 32'h0) report_mismatch("MDIO control while disabled", d, 0);
    repeat (200) begin
      @(negedge clk);
      if (mdc !== 1'b0) report_mismatch("phy_mdc while disabled", mdc, 0);
    end
    finish_test("MDIO disabled", err0);
  endtask

  initial begin
    lfsr_q       = 32'h2e5e_cb3f;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    aresetn      = 1'b0;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    phy_rsp      = '0;
    check_reset_state();
    scratch_readback();
    mdio_write_frame();
    mdio_read_frame();
    back_pressure_hold();
    mdio_disabled();
    $display("Summary: %0d tests run, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
rtl/eth_mgmt_pkg.sv
rtl/axi_wr_chan.sv
rtl/axi_rd_chan.sv
rtl/mgmt_regs.sv
rtl/mdio_master.sv
rtl/eth_mgmt_top.sv
dv/mdio_phy_model.sv
dv/tb_eth_mgmt.sv
